//--- Bender.yml
package:
  name: pipe_cpu

sources:
  - logic/cpuPkg.sv
  - logic/fetchUnit.sv
  - logic/decodeUnit.sv
  - logic/idExReg.sv
  - logic/executeUnit.sv
  - logic/memStage.sv
  - logic/memArbiter.sv
  - logic/cpuTop.sv
  - target: simulation
    files:
      - verif/cpuTb.sv

//--- all.f
logic/cpuPkg.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/idExReg.sv
logic/executeUnit.sv
logic/memStage.sv
logic/memArbiter.sv
logic/cpuTop.sv
verif/cpuTb.sv

//--- logic/cpuPkg.sv
package cpuPkg;

	typedef enum logic [4:0] {
		opHalt = 5'b00000, // Erased memory decodes as HALT
		opNop  = 5'b00001,
		opAddi = 5'b01000,
		opBeqz = 5'b01100,
		opSt   = 5'b10000,
		opLd   = 5'b10001,
		opRFmt = 5'b11011
	} opcodeT;

	typedef enum logic [1:0] {
		aluAdd = 2'b00,
		aluSub = 2'b01,
		aluXor = 2'b10,
		aluAnd = 2'b11
	} aluOpT;

	// R-format and I-format views of the same instruction word
	typedef union packed {
		struct packed {
			opcodeT opcode;
			logic [2:0] rs;
			logic [2:0] rt;
			logic [2:0] rd;
			aluOpT func;
		} rFmt;
		struct packed {
			opcodeT opcode;
			logic [2:0] rs;
			logic [2:0] rd;
			logic [4:0] imm5;
		} iFmt;
	} instrU;

	typedef struct packed {
		logic aluSrcImm;     // 15
		logic [3:0] aluCtrl; // 14:11
		logic isBranch;      // 10
		logic [3:0] spareHi; // 9:6
		logic memEn;         // 5
		logic memWrite;      // 4
		logic isHalt;        // 3
		logic memToReg;      // 2
		logic spareLo;       // 1
		logic regWrite;      // 0
	} ctrlWordT;

	typedef struct packed {
		ctrlWordT ctrl;
		logic [15:0] pcPlus1;
		logic [15:0] readData1;
		logic [15:0] readData2;
		logic [15:0] immExt;
		logic [2:0] writeReg;
		logic haltN;
		logic err;
	} idExT;

	typedef struct packed {
		ctrlWordT ctrl;
		logic [15:0] aluResult;
		logic [15:0] storeData;
		logic [2:0] writeReg;
		logic err;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic isHalt;
		logic [2:0] writeReg;
		logic [15:0] writeData;
		logic err;
	} memWbT;

	typedef struct packed {
		logic en;
		logic write;
		logic [15:0] addr;
		logic [15:0] wdata;
	} memReqT;

	// Empty slot in the decode/execute register
	localparam idExT idBubble = '{haltN: 1'b1, default: '0};

endpackage

//--- logic/cpuTop.sv
module cpuTop #(
	parameter int memDepth = 256
) (
	input logic clk,
	input logic rstN,
	input logic loadEn,
	input logic loadWrite,
	input logic [15:0] loadAddr,
	input logic [15:0] loadWdata,
	output logic [15:0] loadRdata,
	output logic halted,
	output logic err
);
	import cpuPkg::*;

	memReqT loadReq, fetchReq, dataReq;
	instrU instrWord;
	idExT idNext, idEx;
	exMemT exMem;
	memWbT memWb;
	logic fetchGnt, dataGnt, ifValid, stallId, memBusy, redirect;
	logic [15:0] rdata, pcPlus1, redirectPc;

	assign loadReq = '{en: loadEn, write: loadWrite, addr: loadAddr, wdata: loadWdata};

	fetchUnit fetch (.clk, .rstN, .stall(stallId || memBusy), .redirect, .redirectPc,
		.fetchGnt, .rdata, .fetchReq, .instrWord, .pcPlus1, .ifValid);

	decodeUnit decode (.clk, .rstN, .instrWord, .pcPlus1, .ifValid,
		.exDest(idEx.writeReg), .exRegWrite(idEx.ctrl.regWrite),
		.memDest(exMem.writeReg), .memRegWrite(exMem.ctrl.regWrite),
		.memWb, .idNext, .stallId);

	idExReg idExStage (.clk, .rstN, .hold(memBusy), .flush(redirect), .idNext, .idEx);

	executeUnit execute (.clk, .rstN, .hold(memBusy), .idEx, .exMem, .redirect,
		.redirectPc);

	memStage memory (.clk, .rstN, .exMem, .dataGnt, .rdata, .dataReq, .memBusy, .memWb,
		.halted, .err);

	memArbiter #(.memDepth(memDepth)) arbiter (.clk, .rstN, .loadReq, .dataReq, .fetchReq,
		.fetchGnt, .dataGnt, .rdata, .loadRdata);

endmodule

//--- logic/decodeUnit.sv
module decodeUnit (
	input logic clk,
	input logic rstN,
	input cpuPkg::instrU instrWord,
	input logic [15:0] pcPlus1,
	input logic ifValid,
	input logic [2:0] exDest,
	input logic exRegWrite,
	input logic [2:0] memDest,
	input logic memRegWrite,
	input cpuPkg::memWbT memWb,
	output cpuPkg::idExT idNext,
	output logic stallId
);
	import cpuPkg::*;

	logic [15:0] regFile [8];
	ctrlWordT ctrl;
	logic illegal, useRs, useSrc2;
	logic [2:0] rs, src2, dest;
	logic [15:0] readData1, readData2;
	logic hitRs, hitSrc2, hazard;

	always_comb begin
		ctrl = '0;
		illegal = 1'b0;
		useRs = 1'b0;
		useSrc2 = 1'b0;
		rs = instrWord.rFmt.rs;
		src2 = instrWord.rFmt.rt; // Same bits as the store data field of ST
		dest = instrWord.iFmt.rd;
		ctrl.aluCtrl = {2'b00, aluAdd}; // Address and ADDI arithmetic
		case (instrWord.rFmt.opcode)
			opRFmt: begin
				ctrl.aluCtrl = {2'b00, instrWord.rFmt.func};
				ctrl.regWrite = 1'b1;
				useRs = 1'b1;
				useSrc2 = 1'b1;
				dest = instrWord.rFmt.rd;
			end
			opAddi: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				useRs = 1'b1;
			end
			opLd: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memEn = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				useRs = 1'b1;
			end
			opSt: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memEn = 1'b1;
				ctrl.memWrite = 1'b1;
				useRs = 1'b1;
				useSrc2 = 1'b1;
			end
			opBeqz: begin
				ctrl.isBranch = 1'b1;
				useRs = 1'b1;
			end
			opHalt: ctrl.isHalt = 1'b1;
			opNop: ;
			default: illegal = 1'b1;
		endcase
	end

	// Writeback of this cycle is visible to the reads
	always_comb begin
		readData1 = regFile[rs];
		readData2 = regFile[src2];
		if (memWb.regWrite && memWb.writeReg == rs)
			readData1 = memWb.writeData;
		if (memWb.regWrite && memWb.writeReg == src2)
			readData2 = memWb.writeData;
	end

	always_comb begin
		hitRs = (exRegWrite && exDest == rs) || (memRegWrite && memDest == rs);
		hitSrc2 = (exRegWrite && exDest == src2) || (memRegWrite && memDest == src2);
		hazard = (useRs && hitRs) || (useSrc2 && hitSrc2);
		stallId = ifValid && hazard;
		idNext = idBubble;
		if (ifValid && !hazard) begin
			idNext.ctrl = ctrl;
			idNext.pcPlus1 = pcPlus1;
			idNext.readData1 = readData1;
			idNext.readData2 = readData2;
			idNext.immExt = {{11{instrWord.iFmt.imm5[4]}}, instrWord.iFmt.imm5};
			idNext.writeReg = dest;
			idNext.haltN = !ctrl.isHalt;
			idNext.err = illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++)
				regFile[i] <= '0;
		end else if (memWb.regWrite) begin
			regFile[memWb.writeReg] <= memWb.writeData;
		end
	end

endmodule

//--- logic/executeUnit.sv
module executeUnit (
	input logic clk,
	input logic rstN,
	input logic hold,
	input cpuPkg::idExT idEx,
	output cpuPkg::exMemT exMem,
	output logic redirect,
	output logic [15:0] redirectPc
);
	import cpuPkg::*;

	logic [15:0] opB, aluOut;
	logic taken;
	exMemT exNext;

	always_comb begin
		opB = idEx.ctrl.aluSrcImm ? idEx.immExt : idEx.readData2;
		case (aluOpT'(idEx.ctrl.aluCtrl[1:0]))
			aluAdd: aluOut = idEx.readData1 + opB;
			aluSub: aluOut = idEx.readData1 - opB;
			aluXor: aluOut = idEx.readData1 ^ opB;
			default: aluOut = idEx.readData1 & opB;
		endcase
		taken = idEx.ctrl.isBranch && idEx.readData1 == 16'h0000;
		redirect = taken && !hold; // Fires once, when the branch leaves execute
		redirectPc = idEx.pcPlus1 + idEx.immExt;
	end

	always_comb begin
		exNext.ctrl = idEx.ctrl;
		exNext.ctrl.isHalt = !idEx.haltN; // Halt rides the haltN line up to here
		exNext.aluResult = aluOut;
		exNext.storeData = idEx.readData2;
		exNext.writeReg = idEx.writeReg;
		exNext.err = idEx.err;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem.ctrl <= '0;
			exMem.writeReg <= '0;
			exMem.err <= 1'b0;
		end else if (!hold) begin
			exMem <= exNext;
		end
	end

endmodule

//--- logic/fetchUnit.sv
module fetchUnit (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic redirect,
	input logic [15:0] redirectPc,
	input logic fetchGnt,
	input logic [15:0] rdata,
	output cpuPkg::memReqT fetchReq,
	output cpuPkg::instrU instrWord,
	output logic [15:0] pcPlus1,
	output logic ifValid
);

	logic [15:0] pc;
	logic [15:0] pendPc; // Address of the word coming back this cycle
	logic pending;

	assign fetchReq = '{en: !stall, write: 1'b0, addr: pc, wdata: 16'h0000};

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			pending <= 1'b0;
			ifValid <= 1'b0;
		end else if (redirect) begin
			pc <= redirectPc;
			pending <= 1'b0; // Word in flight belongs to the wrong path
			ifValid <= 1'b0;
		end else if (stall) begin
			// Decode is full, so the returning word is dropped and fetched again
			if (pending)
				pc <= pendPc;
			pending <= 1'b0;
		end else begin
			if (fetchGnt)
				pc <= pc + 16'd1;
			pending <= fetchGnt;
			ifValid <= pending;
		end
	end

	always_ff @(posedge clk) begin
		if (fetchGnt)
			pendPc <= pc;
		if (!stall && !redirect) begin
			instrWord <= rdata;
			pcPlus1 <= pendPc + 16'd1;
		end
	end

endmodule

//--- logic/idExReg.sv
module idExReg (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic flush,
	input cpuPkg::idExT idNext,
	output cpuPkg::idExT idEx
);
	import cpuPkg::*;

	// The whole bundle moves on every cycle that is not held
	always_ff @(posedge clk) begin
		if (!rstN || flush)
			idEx <= idBubble; // Bubble: no controls, no error, halt line inactive
		else if (!hold)
			idEx <= idNext;
	end

endmodule

//--- logic/memArbiter.sv
module memArbiter #(
	parameter int memDepth = 256
) (
	input logic clk,
	input logic rstN,
	input cpuPkg::memReqT loadReq,
	input cpuPkg::memReqT dataReq,
	input cpuPkg::memReqT fetchReq,
	output logic fetchGnt,
	output logic dataGnt,
	output logic [15:0] rdata,
	output logic [15:0] loadRdata
);
	import cpuPkg::*;

	localparam int addrW = $clog2(memDepth);

	logic [15:0] mem [memDepth];
	logic [15:0] rdReg;
	logic [addrW-1:0] idx;
	logic loadLast; // Loader owned the port last cycle
	memReqT sel;

	// Loader first, then data, fetch takes what is left
	always_comb begin
		dataGnt = dataReq.en && !loadReq.en;
		fetchGnt = fetchReq.en && !loadReq.en && !dataReq.en;
		if (loadReq.en)
			sel = loadReq;
		else if (dataReq.en)
			sel = dataReq;
		else
			sel = fetchReq;
		idx = addrW'(sel.addr % memDepth);
	end

	always_ff @(posedge clk) begin
		if (sel.en && sel.write)
			mem[idx] <= sel.wdata;
		rdReg <= mem[idx];
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			loadLast <= 1'b0;
		else
			loadLast <= loadReq.en;
	end

	assign rdata = loadLast ? 16'h0000 : rdReg;
	assign loadRdata = loadLast ? rdReg : 16'h0000;

endmodule

//--- logic/memStage.sv
module memStage (
	input logic clk,
	input logic rstN,
	input cpuPkg::exMemT exMem,
	input logic dataGnt,
	input logic [15:0] rdata,
	output cpuPkg::memReqT dataReq,
	output logic memBusy,
	output cpuPkg::memWbT memWb,
	output logic halted,
	output logic err
);
	import cpuPkg::*;

	memWbT wbNext;
	logic isLoad, gotGnt, loadWait, storeWait, stop;

	always_comb begin
		isLoad = exMem.ctrl.memEn && !exMem.ctrl.memWrite;
		dataReq = '{en: exMem.ctrl.memEn && !gotGnt, write: exMem.ctrl.memWrite,
			addr: exMem.aluResult, wdata: exMem.storeData};
		loadWait = isLoad && !gotGnt; // Load data arrives the cycle after its grant
		storeWait = exMem.ctrl.memWrite && !dataGnt;

		// HALT or a bad opcode parks here and freezes everything behind it
		stop = exMem.ctrl.isHalt || exMem.err;
		memBusy = loadWait || storeWait || stop;

		wbNext = '{regWrite: exMem.ctrl.regWrite && !loadWait,
			isHalt: exMem.ctrl.isHalt,
			writeReg: exMem.writeReg,
			writeData: exMem.ctrl.memToReg ? rdata : exMem.aluResult,
			err: exMem.err};
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			gotGnt <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.isHalt <= 1'b0;
			memWb.err <= 1'b0;
			halted <= 1'b0;
			err <= 1'b0;
		end else begin
			gotGnt <= loadWait && dataGnt;
			memWb <= wbNext;
			halted <= halted || memWb.isHalt;
			err <= err || memWb.err;
		end
	end

endmodule

//--- verif/cpuTb.sv
module cpuTb;

	localparam logic [4:0] haltCode = 5'd0;
	localparam logic [4:0] nopCode = 5'd1;
	localparam logic [4:0] addiCode = 5'd8;
	localparam logic [4:0] beqzCode = 5'd12;
	localparam logic [4:0] stCode = 5'd16;
	localparam logic [4:0] ldCode = 5'd17;
	localparam logic [4:0] rCode = 5'd27;
	localparam logic [1:0] fAdd = 2'd0;
	localparam logic [1:0] fSub = 2'd1;
	localparam logic [1:0] fXor = 2'd2;
	localparam logic [1:0] fAnd = 2'd3;

	logic clk = 1'b0;
	logic rstN;
	logic loadEn, loadWrite;
	logic [15:0] loadAddr, loadWdata, loadRdata;
	logic halted, err;

	logic [15:0] image [256];  // Memory image loaded into the DUT
	logic [15:0] expMem [256];
	logic [15:0] gotMem [256]; // Read back after the run
	logic dutHalted, dutErr;
	string testName;
	int slot;
	logic [31:0] lcgState = 32'd21;
	int reqCount = 0;
	int doneCount = 0;
	int passCount = 0;
	int failCount = 0;
	int timeoutCount = 0;

	cpuTop #(.memDepth(256)) uut (.clk, .rstN, .loadEn, .loadWrite, .loadAddr, .loadWdata,
		.loadRdata, .halted, .err);

	always #20 clk = ~clk;

	function automatic logic [15:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	function automatic logic [15:0] rInstr(logic [1:0] func, int rd, int rs, int rt);
		return {rCode, rs[2:0], rt[2:0], rd[2:0], func};
	endfunction

	// For ST the rd field names the register that is stored
	function automatic logic [15:0] iInstr(logic [4:0] op, int rd, int rs, int imm);
		return {op, rs[2:0], rd[2:0], imm[4:0]};
	endfunction

	// ISA-level model that runs expMem in place and returns the error flag
	function automatic logic interpret();
		logic [15:0] regs [8];
		logic [15:0] w, a, b, imm;
		logic [7:0] pc, ea;
		logic errFlag, done;
		for (int r = 0; r < 8; r++)
			regs[r] = '0;
		pc = '0;
		errFlag = 1'b0;
		done = 1'b0;
		for (int step = 0; step < 5000 && !done; step++) begin
			w = expMem[pc];
			a = regs[w[10:8]];
			b = regs[w[7:5]];
			imm = {{11{w[4]}}, w[4:0]};
			ea = a[7:0] + imm[7:0]; // Addresses wrap at 256 words
			pc = pc + 8'd1;
			case (w[15:11])
				haltCode: done = 1'b1;
				nopCode: ;
				addiCode: regs[w[7:5]] = a + imm;
				beqzCode: if (a == 16'h0000) pc = pc + imm[7:0];
				stCode: expMem[ea] = b;
				ldCode: regs[w[7:5]] = expMem[ea];
				rCode: begin
					case (w[1:0])
						fAdd: regs[w[4:2]] = a + b;
						fSub: regs[w[4:2]] = a - b;
						fXor: regs[w[4:2]] = a ^ b;
						default: regs[w[4:2]] = a & b;
					endcase
				end
				default: begin
					errFlag = 1'b1;
					done = 1'b1;
				end
			endcase
		end
		return errFlag;
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	// Unused words decode as HALT and carry their own address
	task automatic newImage();
		for (int i = 0; i < 256; i++)
			image[i] = {8'h00, 8'(i)};
		slot = 0;
	endtask

	task automatic emit(logic [15:0] word);
		image[slot] = word;
		slot++;
	endtask

	task automatic finishRun();
		int failed;
		failed = failCount + timeoutCount;
		$display("Tests run: %0d, passed: %0d, failed: %0d", passCount + failed, passCount,
			failed);
		if (failed == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	task automatic runTest(string name);
		int cycles;
		testName = name;
		nextCycle();
		rstN = 1'b0;
		for (int i = 0; i < 256; i++) begin
			loadEn = 1'b1;
			loadWrite = 1'b1;
			loadAddr = 16'(i);
			loadWdata = image[i];
			nextCycle();
		end
		loadEn = 1'b0;
		loadWrite = 1'b0;
		repeat (5) nextCycle();
		rstN = 1'b1;
		cycles = 0;
		while (!halted && !err && cycles < 2000) begin
			nextCycle();
			cycles++;
		end
		if (!halted && !err) begin
			$display("Test %s: core neither halted nor raised err within 2000 cycles", name);
			timeoutCount++;
			finishRun();
		end
		dutHalted = halted;
		dutErr = err;
		// One read per cycle, data shows up on loadRdata a cycle later
		for (int i = 0; i < 256; i++) begin
			loadEn = 1'b1;
			loadAddr = 16'(i);
			nextCycle();
			gotMem[i] = loadRdata;
		end
		loadEn = 1'b0;
		reqCount++;
		cycles = 0;
		while (doneCount != reqCount && cycles < 2000) begin
			nextCycle();
			cycles++;
		end
		if (doneCount != reqCount) begin
			$display("Test %s: comparison did not finish within 2000 cycles", name);
			timeoutCount++;
			finishRun();
		end
	endtask

	task automatic compareResults();
		logic expErr;
		int bad;
		for (int i = 0; i < 256; i++)
			expMem[i] = image[i];
		expErr = interpret();
		bad = 0;
		if (dutErr !== expErr) begin
			$display("Fail %s err: expected %0b, actual %0b", testName, expErr, dutErr);
			bad++;
		end
		if (dutHalted !== !expErr) begin
			$display("Fail %s halted: expected %0b, actual %0b", testName, !expErr, dutHalted);
			bad++;
		end
		for (int i = 0; i < 256; i++) begin
			if (gotMem[i] !== expMem[i]) begin
				$display("Fail %s mem[0x%02h]: expected 0x%04h, actual 0x%04h", testName, i,
					expMem[i], gotMem[i]);
				bad++;
			end
		end
		if (bad == 0) begin
			passCount++;
			$display("Test %s: ok", testName);
		end else begin
			failCount++;
			$display("Test %s: %0d mismatches", testName, bad);
		end
	endtask

	initial begin
		forever begin
			@(posedge clk);
			if (doneCount != reqCount) begin
				compareResults();
				doneCount++;
			end
		end
	end

	initial begin
		rstN = 1'b0;
		loadEn = 1'b0;
		loadWrite = 1'b0;
		loadAddr = '0;
		loadWdata = '0;
		dutHalted = 1'b0;
		dutErr = 1'b0;
		slot = 0;

		// Operands come from 0xF0 up, results go to 0xF8 up, both reached from r0
		newImage();
		image[8'hF0] = nextRandom();
		image[8'hF1] = nextRandom();
		emit(iInstr(ldCode, 1, 0, -16));
		emit(iInstr(ldCode, 2, 0, -15));
		emit(rInstr(fAdd, 3, 1, 2));
		emit(rInstr(fSub, 4, 1, 2));
		emit(rInstr(fXor, 5, 1, 2));
		emit(rInstr(fAnd, 6, 1, 2));
		emit(iInstr(stCode, 3, 0, -8));
		emit(iInstr(stCode, 4, 0, -7));
		emit(iInstr(stCode, 5, 0, -6));
		emit(iInstr(stCode, 6, 0, -5));
		emit(iInstr(haltCode, 0, 0, 0));
		runTest("aluOps");

		newImage();
		image[8'hF0] = nextRandom();
		emit(iInstr(addiCode, 1, 0, -5));
		emit(iInstr(addiCode, 2, 1, -16));
		emit(iInstr(stCode, 1, 0, -8));
		emit(iInstr(stCode, 2, 0, -7));
		emit(iInstr(ldCode, 4, 0, -16));
		emit(iInstr(addiCode, 5, 1, -3)); // Base 0xFFF8 so that 5(r5) lands on 0xFD
		emit(iInstr(stCode, 4, 5, 5));
		emit(iInstr(ldCode, 6, 5, 5));
		emit(iInstr(addiCode, 6, 6, -1));
		emit(iInstr(stCode, 6, 0, -1));
		emit(iInstr(haltCode, 0, 0, 0));
		runTest("immLdSt");

		// Every instruction needs the one right before it
		newImage();
		image[8'hF0] = nextRandom();
		emit(iInstr(ldCode, 1, 0, -16));
		emit(rInstr(fAdd, 2, 1, 1));
		emit(iInstr(addiCode, 3, 2, 7));
		emit(rInstr(fXor, 4, 3, 1));
		emit(iInstr(stCode, 4, 0, -8));
		emit(iInstr(ldCode, 5, 0, -8));
		emit(rInstr(fSub, 6, 5, 2));
		emit(iInstr(addiCode, 6, 6, -9));
		emit(iInstr(stCode, 6, 0, -7));
		emit(rInstr(fAnd, 7, 6, 4));
		emit(iInstr(stCode, 7, 0, -6));
		emit(iInstr(haltCode, 0, 0, 0));
		runTest("depChain");

		newImage();
		image[8'hF0] = nextRandom() | 16'h0001;
		emit(iInstr(ldCode, 1, 0, -16));
		emit(iInstr(beqzCode, 0, 1, 3));  // Not taken
		emit(iInstr(addiCode, 2, 0, 3));
		emit(iInstr(stCode, 2, 0, -8));
		emit(iInstr(beqzCode, 0, 0, 3));  // Taken to word 8
		emit(iInstr(stCode, 1, 0, -7));
		emit(iInstr(stCode, 1, 0, -6));
		emit(iInstr(stCode, 1, 0, -5));
		emit(iInstr(addiCode, 3, 0, -2));
		emit(iInstr(stCode, 3, 0, -4));
		emit(iInstr(haltCode, 0, 0, 0));
		runTest("branches");

		newImage();
		emit(iInstr(addiCode, 1, 0, 9));
		emit(iInstr(stCode, 1, 0, -8));
		emit(iInstr(haltCode, 0, 0, 0));
		emit(iInstr(stCode, 1, 0, -7));
		emit(iInstr(stCode, 1, 0, -6));
		runTest("haltStop");

		newImage();
		emit(iInstr(addiCode, 1, 0, 4));
		emit(iInstr(stCode, 1, 0, -8));
		emit({5'b00111, 11'h000});
		emit(iInstr(stCode, 1, 0, -7));
		emit(iInstr(haltCode, 0, 0, 0));
		runTest("badOpcode");

		finishRun();
	end

endmodule
